// ==== hw/base_ram.sv ====
// Base RAM with byte lanes
module base_ram
  import soc_pkg::*;
#(
  parameter int RAM_AW = 11
) (
  input  logic    clk,
  input  logic    rst_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  logic [15:0]       mem [2**RAM_AW];
  logic [RAM_AW-1:0] waddr;
  logic              acc;
  logic              ack_q;
  logic [15:0]       dat_q;

  assign waddr = req_i.adr[RAM_AW:1];
  assign acc   = req_i.cyc && req_i.stb && !ack_q;  // No second ack on a held strobe

  always_ff @(posedge clk) begin
    if (acc && req_i.we) begin
      if (req_i.sel[0])
        mem[waddr][7:0] <= req_i.dat[7:0];
      if (req_i.sel[1])
        mem[waddr][15:8] <= req_i.dat[15:8];
    end
    dat_q <= mem[waddr];
  end

  always_ff @(posedge clk) begin
    if (rst_i)
      ack_q <= 1'b0;
    else
      ack_q <= acc;
  end

  assign rsp_o = '{dat: dat_q, ack: ack_q};

  // Strobe stays up until its ack
  a_ack_req: assert property (@(posedge clk) disable iff (rst_i)
    ack_q |-> req_i.cyc && req_i.stb);

endmodule

// ==== hw/bus_switch.sv ====
// Address decoding bus switch
module bus_switch
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  wb_req_t    m_req_i,
  output wb_rsp_t    m_rsp_o,
  output wb_req_t    ram_req_o,
  input  wb_rsp_t    ram_rsp_i,
  output wb_req_t    gpio_req_o,
  input  wb_rsp_t    gpio_rsp_i,
  input  logic       inta_i,
  input  logic       nmia_i,
  input  logic [2:0] iid_i
);

  logic [19:0] tag_adr;
  slave_sel_t  slave_sel;
  logic        def_stb;
  wb_rsp_t     slave_rsp;

  assign tag_adr = {m_req_i.tga, m_req_i.adr};

  // First matching region wins
  always_comb begin
    if ((tag_adr & RAM_MASK) == RAM_MATCH)
      slave_sel = SEL_RAM;
    else if ((tag_adr & GPIO_MASK) == GPIO_MATCH)
      slave_sel = SEL_GPIO;
    else
      slave_sel = SEL_DEF;
  end

  // Fan out request, strobes only to the selected slave
  always_comb begin
    ram_req_o      = m_req_i;
    gpio_req_o     = m_req_i;
    ram_req_o.cyc  = m_req_i.cyc && (slave_sel == SEL_RAM);
    ram_req_o.stb  = m_req_i.stb && (slave_sel == SEL_RAM);
    gpio_req_o.cyc = m_req_i.cyc && (slave_sel == SEL_GPIO);
    gpio_req_o.stb = m_req_i.stb && (slave_sel == SEL_GPIO);
  end

  assign def_stb = m_req_i.cyc && m_req_i.stb && (slave_sel == SEL_DEF);

  always_comb begin
    case (slave_sel)
      SEL_RAM:  slave_rsp = ram_rsp_i;
      SEL_GPIO: slave_rsp = gpio_rsp_i;
      default:  slave_rsp = '{dat: 16'h0000, ack: def_stb}; // Unmapped, zero-wait
    endcase
  end

  // NMI vector beats INTA vector beats slave data
  always_comb begin
    m_rsp_o.ack = slave_rsp.ack;
    if (nmia_i)
      m_rsp_o.dat = NMI_VECTOR;
    else if (inta_i)
      m_rsp_o.dat = IRQ_VECTOR_BASE + {13'd0, iid_i};
    else
      m_rsp_o.dat = slave_rsp.dat;
  end

  // At most one target answers
  a_one_ack: assert property (@(posedge clk) disable iff (rst_i)
    $onehot0({ram_rsp_i.ack, gpio_rsp_i.ack, def_stb}));

endmodule

// ==== hw/gpio_port.sv ====
// Switches, LEDs and pushbutton NMI
module gpio_port
  import soc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_i,
  input  wb_req_t    req_i,
  output wb_rsp_t    rsp_o,
  input  logic [7:0] sw_i,
  input  logic       pb_n_i,
  output logic [7:0] leds_o,
  output logic       nmi_o
);

  logic        acc;
  logic        ack_q;
  logic [15:0] dat_q;
  logic        pb_sync;
  logic        pb_prev;

  assign acc = req_i.cyc && req_i.stb && !ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_q <= acc;
      if (acc && req_i.we && req_i.adr[1] && req_i.sel[0])
        leds_o <= req_i.dat[7:0];  // LED register at 0xf102
    end
  end

  // adr[1] low reads switches
  always_ff @(posedge clk)
    dat_q <= req_i.adr[1] ? {8'h00, leds_o} : {8'h00, sw_i};

  assign rsp_o = '{dat: dat_q, ack: ack_q};

  // Pushbutton is active low
  always_ff @(posedge clk) begin
    if (rst_i) begin
      pb_sync <= 1'b1;
      pb_prev <= 1'b1;
      nmi_o   <= 1'b0;
    end else begin
      pb_sync <= pb_n_i;
      pb_prev <= pb_sync;
      nmi_o   <= pb_prev && !pb_sync;  // One pulse per press
    end
  end

endmodule

// ==== hw/int_ctrl.sv ====
// Fixed priority interrupt controller
module int_ctrl
  import soc_pkg::*;
(
  input  logic               clk,
  input  logic               rst_i,
  input  logic [NUM_IRQ-1:0] irq_i,
  input  logic               inta_i,
  output logic               intr_o,
  output logic [2:0]         iid_o
);

  logic [NUM_IRQ-1:0] irq_q;
  logic [NUM_IRQ-1:0] pend;
  logic [NUM_IRQ-1:0] clr;

  // Acknowledge retires the reported line
  assign clr = {{(NUM_IRQ-1){1'b0}}, inta_i} << iid_o;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q <= '0;
      pend  <= '0;
    end else begin
      irq_q <= irq_i;
      pend  <= (pend & ~clr) | (irq_i & ~irq_q);  // Rising edges only
    end
  end

  // Lowest line wins
  always_comb begin
    iid_o = 3'd0;
    for (int i = NUM_IRQ - 1; i >= 0; i--)
      if (pend[i])
        iid_o = 3'(i);
  end

  assign intr_o = |pend;

  // Master only acknowledges a raised request
  a_inta_intr: assert property (@(posedge clk) disable iff (rst_i)
    inta_i |-> intr_o);

endmodule

// ==== hw/reset_filter.sv ====
// Reset debounce filter
module reset_filter #(
  parameter int DEBOUNCE_W = 17
) (
  input  logic clk,
  input  logic rst_lck,
  output logic sys_rst_o,
  output logic ready_o
);

  logic [DEBOUNCE_W-1:0] cnt;

  always_ff @(posedge clk) begin
    if (!rst_lck) begin
      cnt       <= '1;     // Reload full interval
      sys_rst_o <= 1'b1;
    end else begin
      if (cnt != '0)
        cnt <= cnt - 1'b1;
      sys_rst_o <= (cnt != '0);
    end
  end

  assign ready_o = ~sys_rst_o;

endmodule

// ==== hw/soc_fabric_top.sv ====
// SoC bus fabric top level
module soc_fabric_top
  import soc_pkg::*;
#(
  parameter int RAM_AW     = 11,
  parameter int DEBOUNCE_W = 17
) (
  input  logic               clk,
  input  logic               rst_lck,
  input  wb_req_t            m_req_i,
  output wb_rsp_t            m_rsp_o,
  input  logic               inta_i,
  input  logic               nmia_i,
  input  logic [NUM_IRQ-1:0] irq_i,
  output logic               intr_o,
  output logic [2:0]         iid_o,
  output logic               nmi_o,
  input  logic [7:0]         sw_i,
  input  logic               pb_n_i,
  output logic [7:0]         leds_o,
  output logic               ready_o
);

  logic    sys_rst;
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;
  wb_req_t gpio_req;
  wb_rsp_t gpio_rsp;

  reset_filter #(.DEBOUNCE_W(DEBOUNCE_W)) u_reset_filter (
    .clk       (clk),
    .rst_lck   (rst_lck),
    .sys_rst_o (sys_rst),
    .ready_o   (ready_o)
  );

  bus_switch u_bus_switch (
    .clk        (clk),
    .rst_i      (sys_rst),
    .m_req_i    (m_req_i),
    .m_rsp_o    (m_rsp_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp),
    .inta_i     (inta_i),
    .nmia_i     (nmia_i),
    .iid_i      (iid_o)
  );

  base_ram #(.RAM_AW(RAM_AW)) u_base_ram (
    .clk   (clk),
    .rst_i (sys_rst),
    .req_i (ram_req),
    .rsp_o (ram_rsp)
  );

  gpio_port u_gpio_port (
    .clk    (clk),
    .rst_i  (sys_rst),
    .req_i  (gpio_req),
    .rsp_o  (gpio_rsp),
    .sw_i   (sw_i),
    .pb_n_i (pb_n_i),
    .leds_o (leds_o),
    .nmi_o  (nmi_o)
  );

  int_ctrl u_int_ctrl (
    .clk    (clk),
    .rst_i  (sys_rst),
    .irq_i  (irq_i),
    .inta_i (inta_i),
    .intr_o (intr_o),
    .iid_o  (iid_o)
  );

endmodule

// ==== hw/soc_pkg.sv ====
// SoC bus fabric shared types
package soc_pkg;

  // One master request, Wishbone style
  typedef struct packed {
    logic        tga;   // 1 for I/O space, 0 for memory
    logic [19:1] adr;
    logic [15:0] dat;
    logic [1:0]  sel;
    logic        we;
    logic        cyc;
    logic        stb;
  } wb_req_t;

  // One slave response
  typedef struct packed {
    logic [15:0] dat;
    logic        ack;
  } wb_rsp_t;

  // Request routing target
  typedef enum logic [1:0] {
    SEL_RAM  = 2'd0,
    SEL_GPIO = 2'd1,
    SEL_DEF  = 2'd2
  } slave_sel_t;

  // Match/mask pairs over {tga, adr[19:1]}
  localparam logic [19:0] RAM_MATCH  = 20'b0_0000_0000_0000_0000_000; // mem 0x00000 - 0x00fff
  localparam logic [19:0] RAM_MASK   = 20'b1_1111_1111_0000_0000_000;
  localparam logic [19:0] GPIO_MATCH = 20'b1_0000_1111_0001_0000_000; // io 0xf100 - 0xf103
  localparam logic [19:0] GPIO_MASK  = 20'b1_0000_1111_1111_1111_110;

  // Acknowledge cycle vectors
  localparam logic [15:0] NMI_VECTOR      = 16'h0002;
  localparam logic [15:0] IRQ_VECTOR_BASE = 16'h0008;

  localparam int NUM_IRQ = 8;

endpackage

// ==== list.f ====
+incdir+testbench
hw/soc_pkg.sv
hw/reset_filter.sv
hw/bus_switch.sv
hw/base_ram.sv
hw/gpio_port.sv
hw/int_ctrl.sv
hw/soc_fabric_top.sv
testbench/tb_soc_fabric.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_soc_fabric -o sim_soc_fabric

out=$(./obj_dir/sim_soc_fabric)
echo "$out"
echo "$out" | grep -q "=== PASS ==="

// ==== testbench/tb_model.svh ====
// Reference model for the bus fabric
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [15:0] shadow_ram [2048];
logic [7:0]  shadow_leds;
logic [2:0]  exp_iid;      // Interrupt id the test expects next
logic [31:0] lcg_state;

function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
  return lcg_state;
endfunction

function automatic logic is_ram(input logic tga, input logic [19:1] adr);
  return !tga && ({adr, 1'b0} < 20'h01000);  // Memory 0x00000 to 0x00fff
endfunction

function automatic logic is_gpio(input logic tga, input logic [19:1] adr);
  return tga && ({adr, 1'b0} >= 20'h0f100) && ({adr, 1'b0} <= 20'h0f103);
endfunction

// Track what a write leaves in RAM or in the LED register
function automatic void model_write(input logic tga, input logic [19:1] adr,
                                    input logic [15:0] dat, input logic [1:0] sel);
  if (is_ram(tga, adr)) begin
    if (sel[0])
      shadow_ram[adr[11:1]][7:0] = dat[7:0];
    if (sel[1])
      shadow_ram[adr[11:1]][15:8] = dat[15:8];
  end else if (is_gpio(tga, adr) && adr[1] && sel[0]) begin
    shadow_leds = dat[7:0];
  end
endfunction

// Read data as the master should see it
function automatic logic [15:0] expected_read(input logic tga, input logic [19:1] adr,
                                              input logic inta, input logic nmia);
  if (nmia)
    return 16'h0002;
  if (inta)
    return 16'h0008 + {13'd0, exp_iid};
  if (is_ram(tga, adr))
    return shadow_ram[adr[11:1]];
  if (is_gpio(tga, adr))
    return adr[1] ? {8'h00, shadow_leds} : {8'h00, sw};
  return 16'h0000;  // Unmapped
endfunction

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
    $display("=== FAIL ===");
    $fatal(1, "Mismatch on %s", name);
  end
endtask

`endif

// ==== testbench/tb_soc_fabric.sv ====
// SoC bus fabric testbench
module tb_soc_fabric
  import soc_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  logic       clk;
  logic       rst_lck;
  wb_req_t    m_req;
  wb_rsp_t    m_rsp;
  logic       inta;
  logic       nmia;
  logic [7:0] irq;
  logic       intr;
  logic [2:0] iid;
  logic       nmi;
  logic [7:0] sw;
  logic       pb_n;
  logic [7:0] leds;
  logic       ready;
  int         reads_issued;
  int         reads_checked;
  logic [18:0] addrs [12];

  `include "tb_model.svh"

  soc_fabric_top #(.RAM_AW(11), .DEBOUNCE_W(4)) DUT (
    .clk (clk), .rst_lck (rst_lck), .m_req_i (m_req), .m_rsp_o (m_rsp),
    .inta_i (inta), .nmia_i (nmia), .irq_i (irq), .intr_o (intr),
    .iid_o (iid), .nmi_o (nmi), .sw_i (sw), .pb_n_i (pb_n),
    .leds_o (leds), .ready_o (ready)
  );

  always #5 clk = ~clk;

  task automatic report_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("=== FAIL ===");
    $fatal(1, "Timeout");
  endtask

  // One transfer, held until ack
  task automatic bus_cycle(input logic tga, input logic [19:1] adr, input logic [15:0] dat,
                           input logic [1:0] sel, input logic we,
                           input logic ack_int, input logic ack_nmi);
    int n;
    n = 0;
    @(posedge clk);
    m_req <= '{tga: tga, adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
    inta  <= ack_int;
    nmia  <= ack_nmi;
    if (we)
      model_write(tga, adr, dat, sel);
    else
      reads_issued++;
    do begin
      @(negedge clk);
      n++;
      if (n > 20)
        report_timeout("bus ack");
    end while (!m_rsp.ack);
    @(posedge clk);
    m_req.cyc <= 1'b0;
    m_req.stb <= 1'b0;
    inta      <= 1'b0;
    nmia      <= 1'b0;
  endtask

  // Compare every read response against the model
  always @(negedge clk) begin
    if (ready && m_rsp.ack && m_req.cyc && m_req.stb && !m_req.we) begin
      check("m_rsp_o.dat", 32'(m_rsp.dat), 32'(expected_read(m_req.tga, m_req.adr, inta, nmia)));
      reads_checked++;
    end
  end

  initial begin
    int n;
    logic [31:0] r;
    clk = 0;
    rst_lck = 0;
    m_req = '0;
    inta = 0;
    nmia = 0;
    irq = '0;
    sw = '0;
    pb_n = 1;
    reads_issued = 0;
    reads_checked = 0;
    lcg_state = 32'd95582;
    shadow_leds = '0;
    exp_iid = '0;
    repeat (10) @(posedge clk);
    rst_lck <= 1'b1;
    n = 0;
    do begin                       // Outputs stay quiet until ready
      @(negedge clk);
      check("leds_o", 32'(leds), 32'h0);
      check("intr_o", 32'(intr), 32'h0);
      n++;
      if (n > 100)
        report_timeout("ready_o after reset");
    end while (!ready);

    for (int i = 0; i < 12; i++) begin  // Full words first, then random lanes
      r = lcg_next();
      addrs[i] = {8'h00, r[26:16]};
      r = lcg_next();
      bus_cycle(1'b0, addrs[i], r[23:8], 2'b11, 1'b1, 1'b0, 1'b0);
      r = lcg_next();
      bus_cycle(1'b0, addrs[i], r[23:8], r[29:28], 1'b1, 1'b0, 1'b0);
    end
    foreach (addrs[i])
      bus_cycle(1'b0, addrs[i], 16'h0, 2'b11, 1'b0, 1'b0, 1'b0);

    r = lcg_next();
    @(posedge clk);
    sw <= r[15:8];
    bus_cycle(1'b1, 19'h07880, 16'h0, 2'b11, 1'b0, 1'b0, 1'b0);  // Switches
    bus_cycle(1'b1, 19'h07881, {8'hee, r[23:16]}, 2'b01, 1'b1, 1'b0, 1'b0);
    @(negedge clk);
    check("leds_o", 32'(leds), 32'(r[23:16]));
    bus_cycle(1'b1, 19'h07881, 16'h0, 2'b11, 1'b0, 1'b0, 1'b0);

    bus_cycle(1'b0, 19'h10000, 16'h0, 2'b11, 1'b0, 1'b0, 1'b0);  // Unmapped memory
    bus_cycle(1'b1, 19'h00180, 16'h0, 2'b11, 1'b0, 1'b0, 1'b0);  // Unmapped I/O

    @(posedge clk);
    irq <= 8'b0010_0100;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 20)
        report_timeout("intr_o after irq edges");
    end while (!intr);
    check("iid_o", 32'(iid), 32'd2);
    exp_iid = 3'd2;
    bus_cycle(1'b1, 19'h00010, 16'h0, 2'b11, 1'b0, 1'b1, 1'b0);
    @(negedge clk);
    check("iid_o", 32'(iid), 32'd5);
    check("intr_o", 32'(intr), 32'd1);
    exp_iid = 3'd5;
    bus_cycle(1'b1, 19'h00010, 16'h0, 2'b11, 1'b0, 1'b1, 1'b0);
    @(negedge clk);
    check("intr_o", 32'(intr), 32'd0);

    @(posedge clk);
    pb_n <= 1'b0;                  // Press
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > 20)
        report_timeout("nmi_o after button press");
    end while (!nmi);
    repeat (6) begin               // Single pulse only
      @(negedge clk);
      check("nmi_o", 32'(nmi), 32'd0);
    end
    bus_cycle(1'b1, 19'h00010, 16'h0, 2'b11, 1'b0, 1'b0, 1'b1);
    @(posedge clk);
    pb_n <= 1'b1;
    repeat (2) @(negedge clk);

    check("reads checked", 32'(reads_checked), 32'(reads_issued));
    $display("=== PASS ===");
    $finish;
  end

endmodule
